// File: src.f
+incdir+hw
hw/vrc6_bus_pkg.sv
hw/vrc6_audio_pkg.sv
hw/vrc6_reg_decode.sv
hw/vrc6_bank_map.sv
hw/vrc_irq_timer.sv
hw/vrc6_sound.sv
hw/vrc6_mapper.sv
verification/vrc6_chk.sv
verification/vrc6_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the VRC6 mapper testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module vrc6_tb -f src.f -o vrc6_sim

out=$(./obj_dir/vrc6_sim || true)
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

// File: verification/vrc6_tb.sv
// VRC6 mapper testbench
// Random register writes and bus accesses checked against a reference model
`timescale 1ns/1ns

module vrc6_tb;
	import vrc6_bus_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        ce;
	cpu_bus_t    cpu;
	ppu_addr_t   chr_ain;
	logic        addr_swap;
	logic [15:0] audio_in;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [15:0] audio_out;

	integer      seed;
	int          checks;
	int          errors;

	// Reference model of the mapper registers
	logic [4:0]  m_prg8;
	logic [5:0]  m_prgc;
	logic [7:0]  m_chr [0:7];
	logic [1:0]  m_mirror;

	vrc6_mapper vrc6_mapper_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.addr_swap (addr_swap),
		.audio_in  (audio_in),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq),
		.audio_out (audio_out)
	);

	bind vrc6_mapper vrc6_chk vrc6_chk_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu       (cpu),
		.chr_ain   (chr_ain),
		.prg_allow (prg_allow),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// Any address in the PRG RAM window or ROM space
	function automatic logic [15:0] random_prg_addr();
		logic [31:0] r;
		logic [15:0] a;
		r = next_random();
		a = r[15:0];
		if (!a[15] && a[14:13] != 2'b11)
			a[14:13] = 2'b11;
		return a;
	endfunction

	// Mapper 26 swaps A0 and A1 on the cartridge edge
	function automatic logic [15:0] bus_addr(input logic [15:0] a);
		return addr_swap ? {a[15:2], a[0], a[1]} : a;
	endfunction

	function automatic logic [21:0] expected_prg(input logic [15:0] a);
		logic [8:0] hi;
		case (a[15:13])
		3'b011:         hi = 9'b111100000;
		3'b100, 3'b101: hi = {3'b000, m_prg8, a[13]};
		3'b110:         hi = {3'b000, m_prgc};
		default:        hi = 9'b000111111; // Fixed last bank
		endcase
		return {hi, a[12:0]};
	endfunction

	function automatic logic [21:0] expected_chr(input logic [13:0] a);
		logic [7:0] bank;
		logic       a10;
		bank = m_chr[a[12:10]];
		case (m_mirror)
		2'd0:    a10 = a[10];
		2'd1:    a10 = a[11];
		2'd2:    a10 = 1'b0;
		default: a10 = 1'b1;
		endcase
		if (!a[13])
			a10 = bank[0];
		return {3'b100, 1'b0, bank[7:1], a10, a[9:0]};
	endfunction

	// Upper half of audio_in plus 5/8 of the replicated channel sum
	function automatic logic [15:0] expected_mix(input logic [15:0] ain, input logic [5:0] s);
		logic [15:0] word;
		logic [16:0] sum;
		word = {s, s, s[5:2]};
		sum = {1'b0, ain} + {2'b00, word[15:1]} + {4'b0000, word[15:3]};
		return sum[16:1];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// One CPU cycle of four clocks, ce in the first
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic wr);
		cpu.addr  = a;
		cpu.data  = d;
		cpu.write = wr;
		ce        = 1'b1;
		@(negedge clk);
		ce        = 1'b0;
		cpu.write = 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic reg_write(input logic [15:0] a, input logic [7:0] d);
		bus_cycle(bus_addr(a), d, 1'b1);
	endtask

	// Write level without ce must be ignored
	task automatic write_without_ce(input logic [15:0] a, input logic [7:0] d);
		cpu.addr  = a;
		cpu.data  = d;
		cpu.write = 1'b1;
		repeat (2) @(negedge clk);
		cpu.write = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic check_prg_read(input logic [15:0] a);
		bus_cycle(a, 8'h00, 1'b0);
		compare_value("prg_aout", prg_aout, expected_prg(a));
		compare_value("prg_allow", prg_allow, a[15] || a[15:13] == 3'b011);
	endtask

	task automatic check_chr(input logic [13:0] a);
		logic [21:0] exp;
		exp = expected_chr(a);
		chr_ain = a;
		bus_cycle(16'h0000, 8'h00, 1'b0);
		compare_value("chr_aout", chr_aout, exp);
		compare_value("vram_a10", vram_a10, exp[10]);
		compare_value("vram_ce", vram_ce, a[13]);
	endtask

	task automatic check_audio(input logic [5:0] s);
		logic [31:0] r;
		r = next_random();
		audio_in = r[15:0];
		bus_cycle(16'h0000, 8'h00, 1'b0);
		compare_value("audio_out", audio_out, expected_mix(audio_in, s));
	endtask

	// Counts ce strobes until irq rises
	task automatic wait_for_irq(input int limit, output int strobes);
		strobes = 0;
		while (!irq && strobes < limit) begin
			bus_cycle(16'h0000, 8'h00, 1'b0);
			strobes++;
		end
		checks++;
		assert (irq) else begin
			errors++;
			$display("Timeout at %0t ns: irq did not rise within %0d ce strobes", $time, limit);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [2:0]  idx;
		logic [7:0]  latch;
		int          n;
		int          expected;
		logic        high_seen;

		seed      = 32'h83feee2f;
		checks    = 0;
		errors    = 0;
		clk       = 1'b0;
		rst_n     = 1'b0;
		ce        = 1'b0;
		cpu       = '0;
		chr_ain   = '0;
		addr_swap = 1'b0;
		audio_in  = '0;
		m_prg8    = '0;
		m_prgc    = '0;
		m_mirror  = '0;
		for (int i = 0; i < 8; i++)
			m_chr[i] = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		// Reset state
		compare_value("irq", irq, 1'b0);
		check_audio(6'd0);
		repeat (16) check_prg_read(random_prg_addr());

		// PRG banking with both wirings
		for (int pass = 0; pass < 2; pass++) begin
			addr_swap = (pass == 1);
			for (int i = 0; i < 16; i++) begin
				r = next_random();
				if (r[8]) begin
					reg_write(16'hC000 | {14'd0, r[10:9]}, r[7:0]);
					m_prgc = r[5:0];
				end else begin
					reg_write(16'h8000 | {14'd0, r[10:9]}, r[7:0]);
					m_prg8 = r[4:0];
				end
				write_without_ce(r[8] ? 16'hC000 : 16'h8000, ~r[7:0]);
				repeat (3) check_prg_read(random_prg_addr());
			end
		end

		// CHR banking and mirroring
		for (int i = 0; i < 32; i++) begin
			r = next_random();
			addr_swap = r[31];
			if (r[11:10] == 2'b00) begin
				reg_write(16'hB003, r[7:0]);
				m_mirror = r[3:2];
			end else begin
				idx = r[14:12];
				reg_write((idx[2] ? 16'hE000 : 16'hD000) | {14'd0, idx[1:0]}, r[7:0]);
				m_chr[idx] = r[7:0];
			end
			repeat (4) begin
				r = next_random();
				check_chr(r[13:0]);
			end
		end

		// IRQ in cycle mode
		for (int i = 0; i < 6; i++) begin
			addr_swap = (i % 2 == 1);
			r = next_random();
			latch = r[7:0];
			reg_write(16'hF000, latch);
			reg_write(16'hF001, 8'h06); // M=1, E=1, A=0
			wait_for_irq(300, n);
			expected = 256 - latch;
			checks++;
			assert (n >= expected - 1 && n <= expected + 1) else begin
				errors++;
				$display("** Error at %0t ns: irq strobes = %0d, expected %0d", $time, n, expected);
			end
			reg_write(16'hF002, 8'h00);
			compare_value("irq", irq, 1'b0);
			reg_write(16'hF001, 8'h04); // Counter stopped
			high_seen = 1'b0;
			for (int k = 0; k < 260; k++) begin
				bus_cycle(16'h0000, 8'h00, 1'b0);
				if (irq)
					high_seen = 1'b1;
			end
			compare_value("irq", high_seen, 1'b0);
		end

		// IRQ in scanline mode, two prescaler expiries
		addr_swap = 1'b0;
		reg_write(16'hF000, 8'd254);
		reg_write(16'hF001, 8'h02);
		wait_for_irq(300, n);
		checks++;
		assert (n >= 224 && n <= 230) else begin
			errors++;
			$display("** Error at %0t ns: irq strobes = %0d, expected 224 to 230", $time, n);
		end
		reg_write(16'hF002, 8'h00);
		compare_value("irq", irq, 1'b0);

		// Sound mixing with one pulse channel
		for (int i = 0; i < 4; i++) begin
			addr_swap = (i % 2 == 1);
			r = next_random();
			reg_write(16'h9000, {1'b1, r[6:4], r[3:0]}); // Constant volume
			reg_write(16'h9001, r[15:8]);
			reg_write(16'h9002, {4'h8, r[19:16]});
			repeat (4) check_audio({2'b00, r[3:0]});
			reg_write(16'h9002, 8'h00);
			check_audio(6'd0);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: verification/vrc6_chk.sv
// VRC6 mapper port checker
// Concurrent assertions on the top-level ports, bound into the mapper
`timescale 1ns/1ns

module vrc6_chk (
	input logic                    clk,
	input logic                    rst_n,
	input vrc6_bus_pkg::cpu_bus_t  cpu,
	input vrc6_bus_pkg::ppu_addr_t chr_ain,
	input logic                    prg_allow,
	input logic                    vram_ce,
	input logic                    irq
);

	// Nametable space selects CIRAM
	vram_ce_follows_a13: assert property (@(posedge clk) disable iff (!rst_n)
		vram_ce == chr_ain[13])
	else $error("vram_ce differs from PPU A13");

	irq_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !irq)
	else $error("irq high right after reset release");

	// ROM space is read only
	no_rom_write_allow: assert property (@(posedge clk) disable iff (!rst_n)
		(cpu.write && cpu.addr[15]) |-> !prg_allow)
	else $error("prg_allow high for a write above 0x8000");

endmodule

// File: hw/vrc6_mapper.sv
// VRC6 mapper top level
// Write decoder feeding bank map, IRQ timer and expansion sound
`timescale 1ns/1ns
`include "vrc6_consts.svh"

module vrc6_mapper (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,        // One strobe per CPU cycle
	input  vrc6_bus_pkg::cpu_bus_t      cpu,
	input  vrc6_bus_pkg::ppu_addr_t     chr_ain,
	input  logic                        addr_swap, // High for mapper 26
	input  logic [15:0]                 audio_in,
	output logic [`VRC6_OUT_ADDR_W-1:0] prg_aout,
	output logic                        prg_allow,
	output logic [`VRC6_OUT_ADDR_W-1:0] chr_aout,
	output logic                        vram_a10,
	output logic                        vram_ce,
	output logic                        irq,
	output logic [15:0]                 audio_out
);
	import vrc6_bus_pkg::*;

	reg_write_t wr_cmd;

	vrc6_reg_decode vrc6_reg_decode_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.cpu       (cpu),
		.addr_swap (addr_swap),
		.wr_cmd    (wr_cmd)
	);

	vrc6_bank_map vrc6_bank_map_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_cmd    (wr_cmd),
		.prg_ain   (cpu.addr),
		.prg_write (cpu.write),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

	vrc_irq_timer vrc_irq_timer_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.ce     (ce),
		.wr_cmd (wr_cmd),
		.irq    (irq)
	);

	vrc6_sound vrc6_sound_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ce        (ce),
		.wr_cmd    (wr_cmd),
		.audio_in  (audio_in),
		.audio_out (audio_out)
	);

endmodule

// File: hw/vrc6_sound.sv
// VRC6 expansion sound
// Two pulse channels and a sawtooth, mixed into the APU audio
`timescale 1ns/1ns
`include "vrc6_consts.svh"

module vrc6_sound (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ce,
	input  vrc6_bus_pkg::reg_write_t wr_cmd,
	input  logic [15:0]              audio_in,
	output logic [15:0]              audio_out
);
	import vrc6_bus_pkg::*;
	import vrc6_audio_pkg::*;

	pulse_regs_t pulse [0:1];
	saw_regs_t   saw;
	logic [11:0] pulse_div [0:1];
	logic [3:0]  duty_cnt [0:1];
	logic [12:0] saw_div;
	logic [2:0]  saw_step;
	logic [7:0]  acc;
	chan_out_t   chan;
	logic [5:0]  exp_sum;
	logic [15:0] exp_word;
	logic [16:0] mix;

	// High while the duty step is inside the duty window
	function automatic logic [3:0] pulse_level(input pulse_regs_t r, input logic [3:0] cnt);
		if (r.en && (r.mode || cnt <= {1'b0, r.duty}))
			return r.vol;
		return 4'd0;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) begin
				pulse[i]     <= '0;
				pulse_div[i] <= 12'd0;
				duty_cnt[i]  <= 4'd0;
			end
			saw      <= '0;
			saw_div  <= 13'd0;
			saw_step <= 3'd0;
			acc      <= 8'd0;
		end else begin
			if (ce) begin
				for (int i = 0; i < 2; i++) begin
					if (pulse[i].en) begin
						if (pulse_div[i] != 12'd0) begin
							pulse_div[i] <= pulse_div[i] - 12'd1;
						end else begin
							pulse_div[i] <= pulse[i].freq;
							duty_cnt[i]  <= duty_cnt[i] + 4'd1;
						end
					end
				end
				if (saw.en) begin
					if (saw_div != 13'd0) begin
						saw_div <= saw_div - 13'd1;
					end else begin
						saw_div <= {saw.freq, 1'b1}; // Twice the freq period per step
						if (saw_step == `VRC6_SAW_STEPS) begin
							saw_step <= 3'd0;
							acc      <= 8'd0;
						end else begin
							saw_step <= saw_step + 3'd1;
							acc      <= acc + {2'b00, saw.rate};
						end
					end
				end
			end

			if (wr_cmd.index == 3'd2) begin
				case (wr_cmd.sel)
				REG_SND_CTRL:    saw.rate <= wr_cmd.data[5:0];
				REG_SND_FREQ_LO: saw.freq[7:0] <= wr_cmd.data;
				REG_SND_FREQ_HI: {saw.en, saw.freq[11:8]} <= {wr_cmd.data[7], wr_cmd.data[3:0]};
				default: ;
				endcase
			end else if (wr_cmd.index < 3'd2) begin
				case (wr_cmd.sel)
				REG_SND_CTRL: begin
					{pulse[wr_cmd.index[0]].mode, pulse[wr_cmd.index[0]].duty,
						pulse[wr_cmd.index[0]].vol} <= wr_cmd.data;
				end
				REG_SND_FREQ_LO: pulse[wr_cmd.index[0]].freq[7:0] <= wr_cmd.data;
				REG_SND_FREQ_HI: begin
					pulse[wr_cmd.index[0]].en         <= wr_cmd.data[7];
					pulse[wr_cmd.index[0]].freq[11:8] <= wr_cmd.data[3:0];
				end
				default: ;
				endcase
			end
		end
	end

	always_comb begin
		chan.sq1 = pulse_level(pulse[0], duty_cnt[0]);
		chan.sq2 = pulse_level(pulse[1], duty_cnt[1]);
		chan.saw = saw.en ? acc[7:3] : 5'd0;
	end

	// Expansion level at about 5/8, added before the final halving
	assign exp_sum   = chan.sq1 + chan.sq2 + chan.saw;
	assign exp_word  = {exp_sum, exp_sum, exp_sum[5:2]};
	assign mix       = audio_in + exp_word[15:1] + exp_word[15:3];
	assign audio_out = mix[16:1];

endmodule

// File: hw/vrc_irq_timer.sv
// VRC IRQ timer
// Latch, scanline prescaler and 8-bit up-counter with pending flag
`timescale 1ns/1ns
`include "vrc6_consts.svh"

module vrc_irq_timer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ce,
	input  vrc6_bus_pkg::reg_write_t wr_cmd,
	output logic                     irq
);
	import vrc6_bus_pkg::*;

	logic [7:0] latch;
	logic       irq_m;     // Cycle mode
	logic       irq_a;     // Enable after ack
	logic       irq_e;
	logic [6:0] prescaler;
	logic [1:0] line;      // Position in the 113/113/112 sequence
	logic [7:0] counter;
	logic       pending;
	logic       cnt_clk;

	assign cnt_clk = irq_m || (prescaler == 7'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			latch     <= 8'd0;
			irq_m     <= 1'b0;
			irq_a     <= 1'b0;
			irq_e     <= 1'b0;
			prescaler <= 7'd0;
			line      <= 2'd0;
			counter   <= 8'd0;
			pending   <= 1'b0;
		end else begin
			if (ce && irq_e) begin
				if (prescaler != 7'd0) begin
					prescaler <= prescaler - 7'd1;
				end else begin
					prescaler <= line[1] ? `VRC6_IRQ_SCALER_SHORT : `VRC6_IRQ_SCALER_LONG;
					line      <= line[1] ? 2'd0 : line + 2'd1;
				end
				if (cnt_clk) begin
					if (counter == 8'hFF) begin
						counter <= latch; // Wrap reloads and flags
						pending <= 1'b1;
					end else begin
						counter <= counter + 8'd1;
					end
				end
			end

			// Register writes override the tick
			case (wr_cmd.sel)
			REG_IRQ_LATCH: latch <= wr_cmd.data;
			REG_IRQ_CTRL: begin
				counter   <= latch;
				prescaler <= `VRC6_IRQ_SCALER_LONG;
				line      <= 2'd0;
				pending   <= 1'b0;
				irq_m     <= wr_cmd.data[2];
				irq_e     <= wr_cmd.data[1];
				irq_a     <= wr_cmd.data[0];
			end
			REG_IRQ_ACK: begin
				pending <= 1'b0;
				irq_e   <= irq_a;
			end
			default: ;
			endcase
		end
	end

	assign irq = pending && irq_e;

endmodule

// File: hw/vrc6_bank_map.sv
// VRC6 bank map
// PRG, CHR and mirroring registers with the address translation
`timescale 1ns/1ns
`include "vrc6_consts.svh"

module vrc6_bank_map (
	input  logic                            clk,
	input  logic                            rst_n,
	input  vrc6_bus_pkg::reg_write_t        wr_cmd,
	input  logic [15:0]                     prg_ain,
	input  logic                            prg_write,
	input  vrc6_bus_pkg::ppu_addr_t         chr_ain,
	output logic [`VRC6_OUT_ADDR_W-1:0]     prg_aout,
	output logic                            prg_allow,
	output logic [`VRC6_OUT_ADDR_W-1:0]     chr_aout,
	output logic                            vram_a10,
	output logic                            vram_ce
);
	import vrc6_bus_pkg::*;

	logic [`VRC6_PRG_BANK8_W-1:0] prg_bank8;
	logic [`VRC6_PRG_BANKC_W-1:0] prg_bankc;
	logic [`VRC6_CHR_BANK_W-1:0]  chr_bank [0:7];
	mirror_e                      mirror;
	logic [`VRC6_OUT_ADDR_W-14:0] prg_hi; // Output bits above the 8 KB offset
	logic [`VRC6_CHR_BANK_W-1:0]  chr_sel;
	logic                         mir_a10;
	logic                         ram_win;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank8 <= '0;
			prg_bankc <= '0;
			mirror    <= MIR_VERT;
			for (int i = 0; i < 8; i++) begin
				chr_bank[i] <= '0;
			end
		end else begin
			case (wr_cmd.sel)
			REG_PRG8:   prg_bank8 <= wr_cmd.data[`VRC6_PRG_BANK8_W-1:0];
			REG_PRGC:   prg_bankc <= wr_cmd.data[`VRC6_PRG_BANKC_W-1:0];
			REG_MIRROR: mirror <= mirror_e'(wr_cmd.data[3:2]);
			REG_CHR:    chr_bank[wr_cmd.index] <= wr_cmd.data;
			default: ;
			endcase
		end
	end

	assign ram_win = (prg_ain[15:13] == `VRC6_RAM_WIN);

	always_comb begin
		case (prg_ain[15:13])
		3'b011:         prg_hi = `VRC6_PRG_RAM_BASE;
		3'b100, 3'b101: prg_hi = {3'b000, prg_bank8, prg_ain[13]}; // 16 KB at 0x8000
		3'b110:         prg_hi = {3'b000, prg_bankc};
		3'b111:         prg_hi = {3'b000, `VRC6_PRG_LAST_BANK};
		default:        prg_hi = '0;
		endcase
	end

	assign prg_aout  = {prg_hi, prg_ain[12:0]};
	assign prg_allow = (prg_ain[15] && !prg_write) || ram_win;

	always_comb begin
		case (mirror)
		MIR_VERT:    mir_a10 = chr_ain[10];
		MIR_HORZ:    mir_a10 = chr_ain[11];
		MIR_SCREEN0: mir_a10 = 1'b0;
		default:     mir_a10 = 1'b1;
		endcase
	end

	assign chr_sel  = chr_bank[chr_ain[12:10]];
	assign vram_ce  = chr_ain[13]; // Nametable space goes to CIRAM
	assign chr_aout = {`VRC6_CHR_BASE, 1'b0, chr_sel[7:1],
		vram_ce ? mir_a10 : chr_sel[0], chr_ain[9:0]};
	assign vram_a10 = chr_aout[10];

endmodule

// File: hw/vrc6_reg_decode.sv
// VRC6 write decoder
// Maps sampled CPU writes to one-cycle register write commands
`timescale 1ns/1ns

module vrc6_reg_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    ce,
	input  vrc6_bus_pkg::cpu_bus_t  cpu,
	input  logic                    addr_swap, // Mapper 26 wiring
	output vrc6_bus_pkg::reg_write_t wr_cmd
);
	import vrc6_bus_pkg::*;

	logic [15:0] ain;
	reg_write_t  dec;

	assign ain = addr_swap ? {cpu.addr[15:2], cpu.addr[0], cpu.addr[1]} : cpu.addr;

	always_comb begin
		dec.sel   = REG_NONE;
		dec.index = 3'd0;
		dec.data  = cpu.data;
		case (ain[15:12])
		4'h8: dec.sel = REG_PRG8;
		4'h9, 4'hA, 4'hB: begin
			dec.index = {1'b0, ain[13:12] - 2'd1}; // Channel 0..2
			case (ain[1:0])
			2'd0: dec.sel = REG_SND_CTRL;
			2'd1: dec.sel = REG_SND_FREQ_LO;
			2'd2: dec.sel = REG_SND_FREQ_HI;
			default: dec.sel = (ain[13:12] == 2'b11) ? REG_MIRROR : REG_NONE; // B003 only
			endcase
		end
		4'hC: dec.sel = REG_PRGC;
		4'hD, 4'hE: begin
			dec.sel   = REG_CHR;
			dec.index = {~ain[12], ain[1:0]}; // D000-D003 then E000-E003
		end
		4'hF: begin
			case (ain[1:0])
			2'd0: dec.sel = REG_IRQ_LATCH;
			2'd1: dec.sel = REG_IRQ_CTRL;
			2'd2: dec.sel = REG_IRQ_ACK;
			default: dec.sel = REG_NONE;
			endcase
		end
		default: dec.sel = REG_NONE;
		endcase
	end

	// Command lives for exactly one clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cmd <= '{sel: REG_NONE, index: 3'd0, data: 8'd0};
		end else if (ce && cpu.write) begin
			wr_cmd <= dec;
		end else begin
			wr_cmd.sel <= REG_NONE;
		end
	end

endmodule

// File: hw/vrc6_audio_pkg.sv
// VRC6 expansion sound types
// Channel register sets and the per-channel output levels
package vrc6_audio_pkg;

	typedef struct packed {
		logic        mode; // Constant volume, ignores duty
		logic [2:0]  duty;
		logic [3:0]  vol;
		logic [11:0] freq;
		logic        en;
	} pulse_regs_t;

	typedef struct packed {
		logic [5:0]  rate; // Accumulator increment
		logic [11:0] freq;
		logic        en;
	} saw_regs_t;

	typedef struct packed {
		logic [3:0] sq1;
		logic [3:0] sq2;
		logic [4:0] saw;
	} chan_out_t;

endpackage

// File: hw/vrc6_bus_pkg.sv
// VRC6 bus types
// CPU and PPU buses, register targets and the decoded write command
package vrc6_bus_pkg;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        write; // Write level, sampled with ce
	} cpu_bus_t;

	typedef logic [13:0] ppu_addr_t;

	typedef enum logic [3:0] {
		REG_NONE        = 4'd0,
		REG_PRG8        = 4'd1,
		REG_PRGC        = 4'd2,
		REG_MIRROR      = 4'd3,
		REG_CHR         = 4'd4,
		REG_IRQ_LATCH   = 4'd5,
		REG_IRQ_CTRL    = 4'd6,
		REG_IRQ_ACK     = 4'd7,
		REG_SND_CTRL    = 4'd8,
		REG_SND_FREQ_LO = 4'd9,
		REG_SND_FREQ_HI = 4'd10
	} reg_sel_e;

	typedef struct packed {
		reg_sel_e   sel;
		logic [2:0] index; // CHR bank or sound channel
		logic [7:0] data;
	} reg_write_t;

	typedef enum logic [1:0] {
		MIR_VERT    = 2'd0,
		MIR_HORZ    = 2'd1,
		MIR_SCREEN0 = 2'd2,
		MIR_SCREEN1 = 2'd3
	} mirror_e;

endpackage

// File: hw/vrc6_consts.svh
// VRC6 mapper constants
// Address windows, bank widths, fixed banks and IRQ prescaler reloads
`ifndef VRC6_CONSTS_SVH
`define VRC6_CONSTS_SVH

// Bank register widths
`define VRC6_PRG_BANK8_W 5
`define VRC6_PRG_BANKC_W 6
`define VRC6_CHR_BANK_W 8

// Translated memory address
`define VRC6_OUT_ADDR_W 22

// CPU A15-A13 of the PRG RAM window 0x6000-0x7FFF
`define VRC6_RAM_WIN 3'b011

// Upper output address bits of the PRG RAM and CHR regions
`define VRC6_PRG_RAM_BASE 9'b111100000
`define VRC6_CHR_BASE 3'b100

// 8 KB bank hardwired at 0xE000
`define VRC6_PRG_LAST_BANK 6'b111111

// Scanline prescaler reloads, two long lines then one short
`define VRC6_IRQ_SCALER_LONG 7'd113
`define VRC6_IRQ_SCALER_SHORT 7'd112

// Last step index of the sawtooth accumulator
`define VRC6_SAW_STEPS 3'd6

`endif
